// File: cpu_types_pkg.sv
/*
  ISA types for the MIPS integer subset: data word, register number,
  opcodes, function codes and the instruction field layout
*/
package cpu_types_pkg;

	// one data or address word
	typedef logic [31:0] word_t;
	// register number, 32 registers
	typedef logic [4:0] regbits_t;

	// opcodes kept by this subset
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		J     = 6'h02,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDIU = 6'h09,
		ORI   = 6'h0d,
		LUI   = 6'h0f,
		LW    = 6'h23,
		SW    = 6'h2b,
		HALT  = 6'h3f
	} opcode_t;

	// r-type function codes
	typedef enum logic [5:0] {
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		SLT  = 6'h2a
	} funct_t;

	// r-type view of the low half, pad is the shift amount field
	typedef struct packed {
		regbits_t rd;
		logic [4:0] pad;
		funct_t funct;
	} rlow_t;

	// low half read as immediate or as rd/funct
	typedef union packed {
		logic [15:0] imm;
		rlow_t r;
	} low_t;

	typedef struct packed {
		opcode_t opcode;
		regbits_t rs;
		regbits_t rt;
		low_t low;
	} instr_t;

endpackage

// File: pipe_pkg.sv
/*
  pipeline types: ALU op and forward select enums, decoded control,
  the four pipeline latch structs and the memory port structs
*/
package pipe_pkg;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_PASSB
	} aluop_t;

	// execute operand source
	typedef enum logic [1:0] {
		FWD_LATCH,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	typedef struct packed {
		logic reg_wen;
		// destination is rd, else rt
		logic reg_dst;
		// second ALU operand is the immediate
		logic alu_src;
		aluop_t alu_op;
		logic mem_read;
		logic mem_write;
		logic beq;
		logic bne;
		logic jump;
		logic halt;
	} ctrl_t;

	// fetch/decode latch
	typedef struct packed {
		cpu_types_pkg::instr_t instr;
		cpu_types_pkg::word_t pc4;
	} fd_t;

	// decode/execute latch
	typedef struct packed {
		ctrl_t ctrl;
		cpu_types_pkg::word_t rdat1;
		cpu_types_pkg::word_t rdat2;
		cpu_types_pkg::word_t imm_ext;
		cpu_types_pkg::regbits_t rs;
		cpu_types_pkg::regbits_t rt;
		cpu_types_pkg::regbits_t wsel;
		cpu_types_pkg::instr_t instr;
		cpu_types_pkg::word_t pc4;
	} de_t;

	// execute/memory latch
	typedef struct packed {
		ctrl_t ctrl;
		cpu_types_pkg::word_t alu_out;
		logic zero;
		cpu_types_pkg::word_t store_data;
		cpu_types_pkg::regbits_t wsel;
		cpu_types_pkg::word_t branch_addr;
		cpu_types_pkg::word_t jump_addr;
	} em_t;

	// memory/writeback latch
	typedef struct packed {
		logic reg_wen;
		logic mem_read;
		logic halt;
		cpu_types_pkg::word_t alu_out;
		cpu_types_pkg::word_t load_data;
		cpu_types_pkg::regbits_t wsel;
	} mw_t;

	typedef struct packed {
		logic ren;
		cpu_types_pkg::word_t addr;
	} imem_req_t;

	typedef struct packed {
		logic ren;
		logic wen;
		cpu_types_pkg::word_t addr;
		cpu_types_pkg::word_t store;
	} dmem_req_t;

	// register file write and forwarding value
	typedef struct packed {
		logic wen;
		cpu_types_pkg::regbits_t wsel;
		cpu_types_pkg::word_t wdat;
	} wb_t;

endpackage

// File: register_file.sv
/*
  32-word register file, register 0 reads zero,
  write-through on same-cycle read
*/
`timescale 1ns/10ps

module register_file (
	input logic CLK,
	input logic nRST,
	input pipe_pkg::wb_t wb,
	input cpu_types_pkg::regbits_t rsel1,
	input cpu_types_pkg::regbits_t rsel2,
	output cpu_types_pkg::word_t rdat1,
	output cpu_types_pkg::word_t rdat2
);

	cpu_types_pkg::word_t regs [32];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.wen && wb.wsel != '0) begin
			regs[wb.wsel] <= wb.wdat;
		end
	end

	// pending write seen by decode in the same cycle
	always_comb begin
		rdat1 = regs[rsel1];
		rdat2 = regs[rsel2];
		if (wb.wen && wb.wsel != '0 && wb.wsel == rsel1) begin
			rdat1 = wb.wdat;
		end
		if (wb.wen && wb.wsel != '0 && wb.wsel == rsel2) begin
			rdat2 = wb.wdat;
		end
	end

endmodule

// File: fetch_stage.sv
/*
  program counter, next fetch address select and fetch/decode latch
*/
`timescale 1ns/10ps

module fetch_stage #(
	parameter cpu_types_pkg::word_t PC_INIT = '0
) (
	input logic CLK,
	input logic nRST,
	input logic advance,
	input logic stall,
	input logic redirect,
	input cpu_types_pkg::word_t redirect_addr,
	input cpu_types_pkg::word_t imemload,
	output pipe_pkg::imem_req_t imem_req,
	input logic halted,
	output pipe_pkg::fd_t fd
);

	cpu_types_pkg::word_t pc;
	cpu_types_pkg::word_t pc4;

	assign pc4 = pc + 32'd4;

	// fetch runs until halt
	assign imem_req.ren = !halted;
	assign imem_req.addr = pc;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pc <= PC_INIT;
			fd <= '0;
		end else if (advance) begin
			if (redirect) begin
				// wrong-path word dropped
				pc <= redirect_addr;
				fd <= '0;
			end else if (!stall) begin
				pc <= pc4;
				fd.instr <= cpu_types_pkg::instr_t'(imemload);
				fd.pc4 <= pc4;
			end
		end
	end

endmodule

// File: decode_stage.sv
/*
  instruction decode into control, immediate extension, register
  read and the decode/execute latch
*/
`timescale 1ns/10ps

module decode_stage (
	input logic CLK,
	input logic nRST,
	input logic advance,
	input logic bubble,
	input pipe_pkg::fd_t fd,
	input pipe_pkg::wb_t wb,
	output pipe_pkg::de_t de
);

	cpu_types_pkg::instr_t ins;
	pipe_pkg::ctrl_t ctrl;
	cpu_types_pkg::word_t imm_ext;
	cpu_types_pkg::word_t rdat1;
	cpu_types_pkg::word_t rdat2;

	assign ins = fd.instr;

	register_file rf_i (
		.CLK(CLK), .nRST(nRST), .wb(wb),
		.rsel1(ins.rs), .rsel2(ins.rt),
		.rdat1(rdat1), .rdat2(rdat2)
	);

	always_comb begin
		ctrl = '0;
		case (ins.opcode)
			cpu_types_pkg::RTYPE: begin
				ctrl.reg_wen = 1'b1;
				ctrl.reg_dst = 1'b1;
				case (ins.low.r.funct)
					cpu_types_pkg::ADDU: ctrl.alu_op = pipe_pkg::ALU_ADD;
					cpu_types_pkg::SUBU: ctrl.alu_op = pipe_pkg::ALU_SUB;
					cpu_types_pkg::AND: ctrl.alu_op = pipe_pkg::ALU_AND;
					cpu_types_pkg::OR: ctrl.alu_op = pipe_pkg::ALU_OR;
					cpu_types_pkg::SLT: ctrl.alu_op = pipe_pkg::ALU_SLT;
					// unknown funct, also the all-zero bubble
					default: ctrl.reg_wen = 1'b0;
				endcase
			end
			cpu_types_pkg::ADDIU: begin
				ctrl.reg_wen = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.alu_op = pipe_pkg::ALU_ADD;
			end
			cpu_types_pkg::ORI: begin
				ctrl.reg_wen = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.alu_op = pipe_pkg::ALU_OR;
			end
			cpu_types_pkg::LUI: begin
				ctrl.reg_wen = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.alu_op = pipe_pkg::ALU_PASSB;
			end
			cpu_types_pkg::LW: begin
				ctrl.reg_wen = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.mem_read = 1'b1;
			end
			cpu_types_pkg::SW: begin
				ctrl.alu_src = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			// branches compare by subtract, zero flag
			cpu_types_pkg::BEQ: begin
				ctrl.alu_op = pipe_pkg::ALU_SUB;
				ctrl.beq = 1'b1;
			end
			cpu_types_pkg::BNE: begin
				ctrl.alu_op = pipe_pkg::ALU_SUB;
				ctrl.bne = 1'b1;
			end
			cpu_types_pkg::J: ctrl.jump = 1'b1;
			cpu_types_pkg::HALT: ctrl.halt = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// zero-ext for ori, upper half for lui, sign-ext otherwise
	always_comb begin
		case (ins.opcode)
			cpu_types_pkg::ORI: imm_ext = {16'h0000, ins.low.imm};
			cpu_types_pkg::LUI: imm_ext = {ins.low.imm, 16'h0000};
			default: imm_ext = {{16{ins.low.imm[15]}}, ins.low.imm};
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			de <= '0;
		end else if (advance) begin
			if (bubble) begin
				de <= '0;
			end else begin
				de.ctrl <= ctrl;
				de.rdat1 <= rdat1;
				de.rdat2 <= rdat2;
				de.imm_ext <= imm_ext;
				de.rs <= ins.rs;
				de.rt <= ins.rt;
				de.wsel <= ctrl.reg_dst ? ins.low.r.rd : ins.rt;
				de.instr <= ins;
				de.pc4 <= fd.pc4;
			end
		end
	end

endmodule

// File: execute_stage.sv
/*
  operand forwarding, ALU, branch and jump targets,
  execute/memory latch
*/
`timescale 1ns/10ps

module execute_stage (
	input logic CLK,
	input logic nRST,
	input logic advance,
	input logic bubble,
	input pipe_pkg::de_t de,
	input pipe_pkg::fwd_sel_t fwd_a,
	input pipe_pkg::fwd_sel_t fwd_b,
	input cpu_types_pkg::word_t mem_result,
	input pipe_pkg::wb_t wb,
	output pipe_pkg::em_t em
);

	cpu_types_pkg::word_t opa;
	cpu_types_pkg::word_t regb;
	cpu_types_pkg::word_t opb;
	cpu_types_pkg::word_t alu_out;
	cpu_types_pkg::word_t branch_addr;
	cpu_types_pkg::word_t jump_addr;

	function automatic cpu_types_pkg::word_t pick(
		input pipe_pkg::fwd_sel_t sel,
		input cpu_types_pkg::word_t latched,
		input cpu_types_pkg::word_t from_mem,
		input cpu_types_pkg::word_t from_wb
	);
		case (sel)
			pipe_pkg::FWD_MEM: return from_mem;
			pipe_pkg::FWD_WB: return from_wb;
			default: return latched;
		endcase
	endfunction

	assign opa = pick(fwd_a, de.rdat1, mem_result, wb.wdat);
	// forwarded rt also feeds the store data
	assign regb = pick(fwd_b, de.rdat2, mem_result, wb.wdat);
	assign opb = de.ctrl.alu_src ? de.imm_ext : regb;

	always_comb begin
		case (de.ctrl.alu_op)
			pipe_pkg::ALU_ADD: alu_out = opa + opb;
			pipe_pkg::ALU_SUB: alu_out = opa - opb;
			pipe_pkg::ALU_AND: alu_out = opa & opb;
			pipe_pkg::ALU_OR: alu_out = opa | opb;
			pipe_pkg::ALU_SLT: alu_out = {31'b0, $signed(opa) < $signed(opb)};
			pipe_pkg::ALU_PASSB: alu_out = opb;
			default: alu_out = '0;
		endcase
	end

	// word offset from pc+4
	assign branch_addr = de.pc4 + {de.imm_ext[29:0], 2'b00};
	// pseudo-direct, top nibble of pc+4
	assign jump_addr = {de.pc4[31:28], de.instr[25:0], 2'b00};

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			em <= '0;
		end else if (advance) begin
			if (bubble) begin
				em <= '0;
			end else begin
				em.ctrl <= de.ctrl;
				em.alu_out <= alu_out;
				em.zero <= (alu_out == '0);
				em.store_data <= regb;
				em.wsel <= de.wsel;
				em.branch_addr <= branch_addr;
				em.jump_addr <= jump_addr;
			end
		end
	end

endmodule

// File: mem_wb_stage.sv
/*
  data memory request, branch resolve, memory/writeback latch,
  writeback select and sticky halt
*/
`timescale 1ns/10ps

module mem_wb_stage (
	input logic CLK,
	input logic nRST,
	input logic advance,
	input logic bubble,
	input pipe_pkg::em_t em,
	input cpu_types_pkg::word_t dmemload,
	output pipe_pkg::dmem_req_t dmem_req,
	output logic redirect,
	output cpu_types_pkg::word_t redirect_addr,
	output pipe_pkg::wb_t wb,
	output pipe_pkg::mw_t mw,
	output logic halt
);

	// held from the em latch until the pipeline advances
	assign dmem_req.ren = em.ctrl.mem_read;
	assign dmem_req.wen = em.ctrl.mem_write;
	assign dmem_req.addr = em.alu_out;
	assign dmem_req.store = em.store_data;

	// taken branch or jump
	assign redirect = (em.ctrl.beq && em.zero) || (em.ctrl.bne && !em.zero) || em.ctrl.jump;
	assign redirect_addr = em.ctrl.jump ? em.jump_addr : em.branch_addr;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			mw <= '0;
		end else if (advance) begin
			if (bubble) begin
				mw <= '0;
			end else begin
				mw.reg_wen <= em.ctrl.reg_wen;
				mw.mem_read <= em.ctrl.mem_read;
				mw.halt <= em.ctrl.halt;
				mw.alu_out <= em.alu_out;
				// only meaningful on dhit, which advance implies for loads
				mw.load_data <= dmemload;
				mw.wsel <= em.wsel;
			end
		end
	end

	assign wb.wen = mw.reg_wen;
	assign wb.wsel = mw.wsel;
	assign wb.wdat = mw.mem_read ? mw.load_data : mw.alu_out;

	// set one clock after halt reaches writeback, cleared only by reset
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			halt <= 1'b0;
		end else if (mw.halt) begin
			halt <= 1'b1;
		end
	end

endmodule

// File: hazard_unit.sv
/*
  global advance, load-use stall, flush on redirect or halt,
  forwarding selects for the execute operands
*/
`timescale 1ns/10ps

module hazard_unit (
	input logic ihit,
	input logic dhit,
	input pipe_pkg::fd_t fd,
	input pipe_pkg::de_t de,
	input pipe_pkg::em_t em,
	input pipe_pkg::mw_t mw,
	input logic redirect,
	output logic advance,
	output logic stall,
	output logic bubble_de,
	output logic bubble_em,
	output logic flush,
	output pipe_pkg::fwd_sel_t fwd_a,
	output pipe_pkg::fwd_sel_t fwd_b
);

	logic dmem_busy;
	logic load_use;

	// youngest producer first
	function automatic pipe_pkg::fwd_sel_t fwd_pick(
		input cpu_types_pkg::regbits_t src,
		input pipe_pkg::em_t m,
		input pipe_pkg::mw_t w
	);
		if (m.ctrl.reg_wen && m.wsel != '0 && m.wsel == src) begin
			return pipe_pkg::FWD_MEM;
		end
		if (w.reg_wen && w.wsel != '0 && w.wsel == src) begin
			return pipe_pkg::FWD_WB;
		end
		return pipe_pkg::FWD_LATCH;
	endfunction

	// memory stage access must complete with the fetch
	assign dmem_busy = em.ctrl.mem_read || em.ctrl.mem_write;
	assign advance = ihit && (dhit || !dmem_busy);

	// load in execute feeding decode, rt checked even when not a source
	assign load_use = de.ctrl.mem_read && de.wsel != '0 &&
		(de.wsel == fd.instr.rs || de.wsel == fd.instr.rt);

	// resolved branch or halt in memory stage kills fd, de and em
	assign flush = redirect || em.ctrl.halt;
	assign stall = load_use && !flush;
	assign bubble_de = flush || load_use;
	assign bubble_em = flush;

	assign fwd_a = fwd_pick(de.rs, em, mw);
	assign fwd_b = fwd_pick(de.rt, em, mw);

endmodule

// File: datapath.sv
/*
  five-stage pipelined datapath top: fetch, decode, execute,
  memory/writeback stages and the hazard unit
*/
`timescale 1ns/10ps

module datapath #(
	parameter cpu_types_pkg::word_t PC_INIT = '0
) (
	input logic CLK,
	input logic nRST,
	input logic ihit,
	input cpu_types_pkg::word_t imemload,
	output pipe_pkg::imem_req_t imem_req,
	input logic dhit,
	input cpu_types_pkg::word_t dmemload,
	output pipe_pkg::dmem_req_t dmem_req,
	output logic halt
);

	// pipeline latches
	pipe_pkg::fd_t fd;
	pipe_pkg::de_t de;
	pipe_pkg::em_t em;
	pipe_pkg::mw_t mw;
	// writeback to register file and forwarding
	pipe_pkg::wb_t wb;

	// branch or jump resolved in memory stage
	logic redirect;
	cpu_types_pkg::word_t redirect_addr;

	// hazard controls
	logic advance;
	logic stall;
	logic bubble_de;
	logic bubble_em;
	logic flush;
	pipe_pkg::fwd_sel_t fwd_a;
	pipe_pkg::fwd_sel_t fwd_b;

	// fetch bubbles fd on any flush, a halt flush refetches near the halt
	fetch_stage #(.PC_INIT(PC_INIT)) fetch_i (
		.CLK(CLK), .nRST(nRST),
		.advance(advance), .stall(stall),
		.redirect(flush), .redirect_addr(redirect_addr),
		.imemload(imemload), .imem_req(imem_req),
		.halted(halt), .fd(fd)
	);

	decode_stage decode_i (
		.CLK(CLK), .nRST(nRST),
		.advance(advance), .bubble(bubble_de),
		.fd(fd), .wb(wb), .de(de)
	);

	execute_stage execute_i (
		.CLK(CLK), .nRST(nRST),
		.advance(advance), .bubble(bubble_em),
		.de(de), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.mem_result(em.alu_out), .wb(wb), .em(em)
	);

	// writeback latch frozen with bubbles once halted
	mem_wb_stage mem_wb_i (
		.CLK(CLK), .nRST(nRST),
		.advance(advance), .bubble(halt),
		.em(em), .dmemload(dmemload), .dmem_req(dmem_req),
		.redirect(redirect), .redirect_addr(redirect_addr),
		.wb(wb), .mw(mw), .halt(halt)
	);

	hazard_unit hazard_i (
		.ihit(ihit), .dhit(dhit),
		.fd(fd), .de(de), .em(em), .mw(mw),
		.redirect(redirect),
		.advance(advance), .stall(stall),
		.bubble_de(bubble_de), .bubble_em(bubble_em), .flush(flush),
		.fwd_a(fwd_a), .fwd_b(fwd_b)
	);

endmodule

// File: datapath_chk.sv
/*
  bound assertions on the datapath memory handshake and halt,
  plus the bind onto the datapath
*/
`timescale 1ns/10ps

module datapath_chk (
	input logic CLK,
	input logic nRST,
	input pipe_pkg::imem_req_t imem_req,
	input pipe_pkg::dmem_req_t dmem_req,
	input logic dhit,
	input logic halt
);

	// failure tally, read by the testbench summary
	int fails = 0;

	// one data access at a time
	no_dual_access: assert property (@(posedge CLK) disable iff (!nRST)
		!(dmem_req.ren && dmem_req.wen))
	else begin
		$error("data read and write enables both high");
		fails++;
	end

	// sticky halt
	halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
	else begin
		$error("halt fell without reset");
		fails++;
	end

	no_fetch_halted: assert property (@(posedge CLK) disable iff (!nRST)
		halt |-> !imem_req.ren)
	else begin
		$error("instruction fetch while halted");
		fails++;
	end

	// pending data access keeps its address
	addr_held: assert property (@(posedge CLK) disable iff (!nRST)
		((dmem_req.ren || dmem_req.wen) && !dhit) |=> $stable(dmem_req.addr))
	else begin
		$error("data address changed before dhit");
		fails++;
	end

endmodule

bind datapath datapath_chk chk_i (
	.CLK(CLK), .nRST(nRST), .imem_req(imem_req),
	.dmem_req(dmem_req), .dhit(dhit), .halt(halt)
);

// File: datapath_tb.sv
/*
  datapath testbench: clock, reset, shared word memory with random
  wait states, stimulus file reader, checks, watchdog and summary
*/
`timescale 1ns/10ps

module datapath_tb;

	localparam int MAX_CYCLES = 2000;
	localparam int PERIOD = 40;

	// one stimulus file line
	typedef struct packed {
		logic [7:0] kind;
		logic [15:0] test;
		cpu_types_pkg::word_t addr;
		cpu_types_pkg::word_t data;
	} entry_t;

	logic CLK;
	logic nRST;
	logic ihit;
	logic dhit;
	logic halt;
	logic loaded;
	logic opened;
	cpu_types_pkg::word_t imemload;
	cpu_types_pkg::word_t dmemload;
	pipe_pkg::imem_req_t imem_req;
	pipe_pkg::dmem_req_t dmem_req;

	cpu_types_pkg::word_t mem [256];
	string test_names[$];
	entry_t entries[$];
	int test_errors;
	int failed_checks;
	int failed_tests;
	// memory model wait counters, -1 means no request seen
	int i_wait;
	int d_wait;
	cpu_types_pkg::word_t i_last;
	pipe_pkg::dmem_req_t d_last;

	datapath #(.PC_INIT(32'h0000_0000)) datapath_i (
		.CLK(CLK), .nRST(nRST),
		.ihit(ihit), .imemload(imemload), .imem_req(imem_req),
		.dhit(dhit), .dmemload(dmemload), .dmem_req(dmem_req),
		.halt(halt)
	);

	always #(PERIOD / 2) CLK = ~CLK;

	// answers 0 to 3 cycles after a new request, hit held while it stays
	always @(posedge CLK) begin
		#2;
		if (!imem_req.ren) begin
			ihit = 1'b0;
			i_wait = -1;
		end else begin
			if (i_wait < 0 || imem_req.addr !== i_last) begin
				i_last = imem_req.addr;
				i_wait = int'($urandom % 4);
			end else if (i_wait > 0) begin
				i_wait--;
			end
			ihit = (i_wait == 0);
		end
		imemload = mem[imem_req.addr[9:2]];
		if (!(dmem_req.ren || dmem_req.wen)) begin
			dhit = 1'b0;
			d_wait = -1;
		end else begin
			if (d_wait < 0 || dmem_req !== d_last) begin
				d_last = dmem_req;
				d_wait = int'($urandom % 4);
			end else if (d_wait > 0) begin
				d_wait--;
			end
			dhit = (d_wait == 0);
		end
		dmemload = mem[dmem_req.addr[9:2]];
	end

	// store lands mid-cycle, inputs settled
	always @(negedge CLK) begin
		if (nRST && dhit && dmem_req.wen) begin
			mem[dmem_req.addr[9:2]] = dmem_req.store;
		end
	end

	task automatic compare_word(input string what, input cpu_types_pkg::word_t exp,
		input cpu_types_pkg::word_t act);
		if (exp !== act) begin
			$display("Error: %s expected %h actual %h", what, exp, act);
			failed_checks++;
			test_errors++;
		end
	endtask

	task automatic read_stimulus(output logic ok);
		int fd;
		int n;
		string line;
		string tag;
		string nm;
		entry_t e;
		ok = 1'b0;
		fd = $fopen("datapath_stimulus.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s", tag);
					if (tag == "T") begin
						n = $sscanf(line, "%s %s", tag, nm);
						test_names.push_back(nm);
					end else begin
						n = $sscanf(line, "%s %h %h", tag, e.addr, e.data);
						e.kind = tag.getc(0);
						e.test = 16'(test_names.size() - 1);
						entries.push_back(e);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_test(input int t);
		int cycles;
		@(posedge CLK);
		#2;
		nRST = 1'b0;
		// fill word is not a kept opcode
		for (int i = 0; i < 256; i++) begin
			mem[i] = 32'hbad0_0000 | 32'(i * 4);
		end
		foreach (entries[k]) begin
			if (entries[k].test == 16'(t) && entries[k].kind == "P") begin
				mem[entries[k].addr[9:2]] = entries[k].data;
			end
		end
		repeat (8) @(posedge CLK);
		#2;
		nRST = 1'b1;
		test_errors = 0;
		cycles = 0;
		while (!halt && cycles < MAX_CYCLES) begin
			@(negedge CLK);
			cycles++;
		end
		if (!halt) begin
			$display("test %s: halt not reached within %0d cycles", test_names[t], MAX_CYCLES);
			test_errors++;
		end else begin
			// late stores would show up here
			repeat (10) @(negedge CLK);
			compare_word({test_names[t], " halt"}, 32'd1, 32'(halt));
			foreach (entries[k]) begin
				if (entries[k].test == 16'(t) && entries[k].kind == "E") begin
					compare_word($sformatf("%s @%h", test_names[t], entries[k].addr),
						entries[k].data, mem[entries[k].addr[9:2]]);
				end
			end
		end
		if (test_errors == 0) begin
			$display("test %s: ok after %0d cycles", test_names[t], cycles);
		end else begin
			$display("test %s: failed with %0d errors", test_names[t], test_errors);
			failed_tests++;
		end
	endtask

	initial begin
		CLK = 1'b0;
		nRST = 1'b0;
		ihit = 1'b0;
		dhit = 1'b0;
		imemload = '0;
		dmemload = '0;
		loaded = 1'b0;
		opened = 1'b0;
		failed_checks = 0;
		failed_tests = 0;
		i_wait = -1;
		d_wait = -1;
		void'($urandom(32'h4226_ae42));
		read_stimulus(opened);
		if (!opened) begin
			$display("cannot open the stimulus file datapath_stimulus.txt");
			$display("STATUS: FAIL");
			$finish;
		end else begin
			loaded = 1'b1;
			foreach (test_names[t]) begin
				run_test(t);
			end
			$display("tests %0d, failed %0d, failed checks %0d, assertion failures %0d",
				test_names.size(), failed_tests, failed_checks, datapath_i.chk_i.fails);
			if (failed_tests == 0 && datapath_i.chk_i.fails == 0) begin
				$display("STATUS: PASS");
			end else begin
				$display("STATUS: FAIL");
			end
			$finish;
		end
	end

	// budget per test plus reset
	initial begin
		wait (loaded);
		#(longint'(test_names.size()) * (MAX_CYCLES + 40) * PERIOD);
		$display("watchdog: simulation ran past the time allowed for all tests");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: datapath_stimulus.txt
# T name: starts a test
# P addr word: program or data word loaded before reset ends, E addr word: memory word after halt
T alu_imm
P 000 24010007
P 004 2402fffd
P 008 00221821
P 00c 00222023
P 010 00222824
P 014 00223025
P 018 0041382a
P 01c 34088001
P 020 3c091234
P 024 ac030200
P 028 ac040204
P 02c ac050208
P 030 ac06020c
P 034 ac070210
P 038 ac080214
P 03c ac090218
P 040 fc000000
E 200 00000004
E 204 0000000a
E 208 00000005
E 20c ffffffff
E 210 00000001
E 214 00008001
E 218 12340000
T forwarding
P 000 24010005
P 004 00211021
P 008 00411821
P 00c 00622023
P 010 ac040220
P 014 ac030224
P 018 24210001
P 01c ac010228
P 020 fc000000
E 220 00000005
E 224 0000000f
E 228 00000006
T load_use
P 240 00000064
P 244 00000011
P 000 8c010240
P 004 8c020244
P 008 00221821
P 00c ac030248
P 010 8c040248
P 014 00842821
P 018 ac05024c
P 01c fc000000
E 248 00000075
E 24c 000000ea
T control_flow
P 260 00000000
P 268 00000000
P 26c 00000000
P 000 24010001
P 004 24020001
P 008 10220001
P 00c ac010260
P 010 14220001
P 014 ac010264
P 018 08000008
P 01c ac010268
P 020 14200001
P 024 ac01026c
P 028 ac020270
P 02c fc000000
E 260 00000000
E 264 00000001
E 268 00000000
E 26c 00000000
E 270 00000001
T halt_waits
P 284 00000000
P 288 00000000
P 000 24010055
P 004 ac010280
P 008 fc000000
P 00c ac010284
P 010 ac010288
E 280 00000055
E 284 00000000
E 288 00000000

// File: tb.f
cpu_types_pkg.sv
pipe_pkg.sv
register_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
hazard_unit.sv
datapath.sv
datapath_chk.sv
datapath_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module datapath_tb -f tb.f -o datapath_sim
output=$(./obj_dir/datapath_sim +verilator+error+limit+100)
echo "$output"
if grep -qx "STATUS: PASS" <<< "$output"; then
	exit 0
else
	exit 1
fi
